/* or1k_dcod_top.f */
+incdir+tb
rtl/or1k_dcod_pkg.sv
rtl/or1k_dcod_classify.sv
rtl/or1k_dcod_operands.sv
rtl/or1k_dcod_exec_latch.sv
rtl/or1k_dcod_top.sv
tb/or1k_dcod_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the decode stage testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module or1k_dcod_tb \
  -Mdir "$OBJ_DIR" \
  -f or1k_dcod_top.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/Vor1k_dcod_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished without failure"
exit 0

/* tb/or1k_dcod_vectors.svh */
// decode stage test vectors, instruction stimulus with the expected branch and execute results
`ifndef OR1K_DCOD_VECTORS_SVH
`define OR1K_DCOD_VECTORS_SVH

`default_nettype none

typedef struct packed {
  logic [31:0] insn;
  logic [31:0] pc;
  logic        flag;
  // {target is checked, expected branch_o}
  logic [1:0]  jmp_br;
  logic [31:0] target;
  logic [3:0]  alu;
  // {op_add, do_sub, do_carry, op_movhi, op_jal, op_brcond}
  logic [5:0]  ctl;
  // {load, store}
  logic [1:0]  ld_st;
  logic [1:0]  len;
  logic        zext;
  logic [31:0] imm;
  logic        imm_sel;
  logic [4:0]  rfd;
  // {writeback, one clock}
  logic [1:0]  wb_1clk;
  // {illegal, syscall, trap}
  logic [2:0]  exc;
} vec_row_t;

localparam int NUM_ROWS = 27;

// first line: insn, pc, flag
// second line: jmp_br, target, alu, ctl, ld_st, len, zext, imm, imm_sel, rfd, wb_1clk, exc
localparam vec_row_t VECTORS [NUM_ROWS] = '{
  // addi, addic, andi, ori, xori, movhi
  '{32'h9c64fffe, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h0, 6'b100000, 2'b00, 2'd2, 1'b1, 32'hfffffffe, 1'b1, 5'd3, 2'b11, 3'b000},
  '{32'ha0a67fff, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h0, 6'b101000, 2'b00, 2'd2, 1'b0, 32'h00007fff, 1'b1, 5'd5, 2'b11, 3'b000},
  '{32'ha4e88001, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h3, 6'b000000, 2'b00, 2'd2, 1'b1, 32'h00008001, 1'b1, 5'd7, 2'b11, 3'b000},
  '{32'ha822f0f0, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h4, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h0000f0f0, 1'b1, 5'd1, 2'b11, 3'b000},
  '{32'had2a8000, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h5, 6'b000000, 2'b00, 2'd2, 1'b1, 32'hffff8000, 1'b1, 5'd9, 2'b11, 3'b000},
  '{32'h1960abcd, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000100, 2'b00, 2'd2, 1'b0, 32'habcd0000, 1'b1, 5'd11, 2'b11, 3'b000},
  // register alu ops add, sub, xor
  '{32'he18d7000, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h0, 6'b100000, 2'b00, 2'd2, 1'b0, 32'h00000000, 1'b0, 5'd12, 2'b11, 3'b000},
  '{32'he0432002, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h2, 6'b110000, 2'b00, 2'd2, 1'b0, 32'h00000000, 1'b0, 5'd2, 2'b11, 3'b000},
  '{32'he0c74005, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'h5, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h00000000, 1'b0, 5'd6, 2'b11, 3'b000},
  // lwz, lbs, lhz
  '{32'h84640010, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b10, 2'd2, 1'b1, 32'h00000010, 1'b1, 5'd3, 2'b10, 3'b000},
  '{32'h90a6fffc, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b10, 2'd0, 1'b0, 32'hfffffffc, 1'b1, 5'd5, 2'b10, 3'b000},
  '{32'h94e80022, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b10, 2'd1, 1'b1, 32'h00000022, 1'b1, 5'd7, 2'b10, 3'b000},
  // sw, sb, sh with the split immediate
  '{32'hd4032024, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b01, 2'd2, 1'b1, 32'h00000024, 1'b1, 5'd0, 2'b00, 3'b000},
  '{32'hdbe537f8, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b01, 2'd0, 1'b0, 32'hfffffff8, 1'b1, 5'd31, 2'b00, 3'b000},
  '{32'hdc270804, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b01, 2'd1, 1'b1, 32'h00000804, 1'b1, 5'd1, 2'b00, 3'b000},
  // j, jal, then bf and bnf with both flag values
  '{32'h00000010, 32'h00002000, 1'b0,
    2'b11, 32'h00002040, 4'hf, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd0, 2'b01, 3'b000},
  '{32'h07fffffc, 32'h80000100, 1'b0,
    2'b11, 32'h800000f0, 4'hf, 6'b000010, 2'b00, 2'd2, 1'b1, 32'h0, 1'b0, 5'd9, 2'b11, 3'b000},
  '{32'h10000008, 32'h00002000, 1'b1,
    2'b11, 32'h00002020, 4'hf, 6'b000001, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd0, 2'b01, 3'b000},
  '{32'h10000008, 32'h00002000, 1'b0,
    2'b10, 32'h00002020, 4'hf, 6'b000001, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd0, 2'b01, 3'b000},
  '{32'h0c000100, 32'h00400000, 1'b0,
    2'b11, 32'h00400400, 4'hf, 6'b000001, 2'b00, 2'd2, 1'b1, 32'h0, 1'b0, 5'd0, 2'b01, 3'b000},
  '{32'h0c000100, 32'h00400000, 1'b1,
    2'b10, 32'h00400400, 4'hf, 6'b000001, 2'b00, 2'd2, 1'b1, 32'h0, 1'b0, 5'd0, 2'b01, 3'b000},
  // l.mul, shift group, msync, sys, trap, nop
  '{32'he0000006, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd0, 2'b01, 3'b100},
  '{32'hb8000000, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd0, 2'b01, 3'b100},
  '{32'h22000000, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd16, 2'b01, 3'b100},
  '{32'h20000001, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd0, 2'b01, 3'b010},
  '{32'h21000001, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b00, 2'd2, 1'b0, 32'h0, 1'b0, 5'd8, 2'b01, 3'b001},
  '{32'h15000000, 32'h00002000, 1'b0,
    2'b00, 32'h0, 4'hf, 6'b000000, 2'b00, 2'd2, 1'b1, 32'h0, 1'b0, 5'd8, 2'b01, 3'b000}
};

`default_nettype wire

`endif

/* tb/or1k_dcod_tb.sv */
// decode stage testbench, table and random instructions, hold, flush and reset checks
`timescale 1ns/10ps
`include "or1k_dcod_vectors.svh"
`default_nettype none

module or1k_dcod_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 4;
  localparam int RND_ROWS   = 8;
  localparam int CTRL_ROWS  = 8;
  // 4 cycles of budget for each row
  localparam int WATCHDOG_NS =
    ((NUM_ROWS + RND_ROWS + CTRL_ROWS) * 4 + RST_CYCLES) * CLK_PERIOD;

  logic                        clk;
  logic                        rst;
  logic                        padv;
  logic                        flush;
  logic [31:0]                 insn;
  logic                        insn_valid;
  logic [31:0]                 pc;
  logic                        flag;
  logic [4:0]                  rfa_adr;
  logic [4:0]                  rfb_adr;
  logic                        branch;
  logic [31:0]                 branch_target;
  or1k_dcod_pkg::dcod_op_t     exec_op;
  or1k_dcod_pkg::dcod_except_t exec_except;
  logic [31:0]                 exec_imm;
  logic                        exec_imm_sel;
  logic [4:0]                  exec_rfd_adr;
  logic                        exec_rf_wb;
  logic [31:0]                 exec_link;
  logic [31:0]                 exec_pc;
  logic                        exec_insn_1clk;
  logic                        exec_excepts_en;

  int       seed;
  int       err_count;
  int       test_errs;
  int       test_count;
  int       failed_tests;
  vec_row_t rnd_row;

  or1k_dcod_top dut_i (
    .clk               (clk),
    .rst               (rst),
    .padv_decode_i     (padv),
    .pipeline_flush_i  (flush),
    .insn_i            (insn),
    .insn_valid_i      (insn_valid),
    .pc_i              (pc),
    .flag_i            (flag),
    .rfa_adr_o         (rfa_adr),
    .rfb_adr_o         (rfb_adr),
    .branch_o          (branch),
    .branch_target_o   (branch_target),
    .exec_op_o         (exec_op),
    .exec_except_o     (exec_except),
    .exec_imm_o        (exec_imm),
    .exec_imm_sel_o    (exec_imm_sel),
    .exec_rfd_adr_o    (exec_rfd_adr),
    .exec_rf_wb_o      (exec_rf_wb),
    .exec_link_o       (exec_link),
    .exec_pc_o         (exec_pc),
    .exec_insn_1clk_o  (exec_insn_1clk),
    .exec_excepts_en_o (exec_excepts_en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("** FAIL **");
    $finish;
  end

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (test_errs == 0) begin
      $display("test %0d %s ok", test_count, name);
    end else begin
      failed_tests++;
      $display("test %0d %s failed with %0d errors", test_count, name, test_errs);
    end
    test_errs = 0;
  endtask

  // reset and flush leave an empty one-clock slot
  task automatic idle_control_check();
    expect_eq("exec_op_o", 32'(exec_op), 32'd0);
    expect_eq("exec_except_o", 32'(exec_except), 32'd0);
    expect_eq("exec_rf_wb_o", 32'(exec_rf_wb), 32'd0);
    expect_eq("exec_excepts_en_o", 32'(exec_excepts_en), 32'd0);
    expect_eq("exec_insn_1clk_o", 32'(exec_insn_1clk), 32'd1);
  endtask

  task automatic run_vector(input vec_row_t row, input string name);
    @(posedge clk);
    insn       <= row.insn;
    pc         <= row.pc;
    flag       <= row.flag;
    insn_valid <= 1'b1;
    padv       <= 1'b1;
    // same-cycle outputs are settled by the falling edge
    @(negedge clk);
    expect_eq("branch_o", 32'(branch), 32'(row.jmp_br[0]));
    if (row.jmp_br[1]) begin
      expect_eq("branch_target_o", branch_target, row.target);
    end
    expect_eq("rfa_adr_o", 32'(rfa_adr), 32'(row.insn[20:16]));
    expect_eq("rfb_adr_o", 32'(rfb_adr), 32'(row.insn[15:11]));
    @(posedge clk);
    padv <= 1'b0;
    @(negedge clk);
    expect_eq("exec_op_o.alu_opc", 32'(exec_op.alu_opc), 32'(row.alu));
    expect_eq("exec_op_o flags",
              32'({exec_op.op_add, exec_op.do_sub, exec_op.do_carry,
                   exec_op.op_movhi, exec_op.op_jal, exec_op.op_brcond}),
              32'(row.ctl));
    expect_eq("exec_op_o.lsu_load", 32'(exec_op.lsu_load), 32'(row.ld_st[1]));
    expect_eq("exec_op_o.lsu_store", 32'(exec_op.lsu_store), 32'(row.ld_st[0]));
    expect_eq("exec_op_o.lsu_len", 32'(exec_op.lsu_len), 32'(row.len));
    expect_eq("exec_op_o.lsu_zext", 32'(exec_op.lsu_zext), 32'(row.zext));
    expect_eq("exec_imm_o", exec_imm, row.imm);
    expect_eq("exec_imm_sel_o", 32'(exec_imm_sel), 32'(row.imm_sel));
    expect_eq("exec_rfd_adr_o", 32'(exec_rfd_adr), 32'(row.rfd));
    expect_eq("exec_rf_wb_o", 32'(exec_rf_wb), 32'(row.wb_1clk[1]));
    expect_eq("exec_insn_1clk_o", 32'(exec_insn_1clk), 32'(row.wb_1clk[0]));
    expect_eq("exec_except_o", 32'(exec_except), 32'(row.exc));
    expect_eq("exec_excepts_en_o", 32'(exec_excepts_en), 32'd1);
    expect_eq("exec_pc_o", exec_pc, row.pc);
    expect_eq("exec_link_o", exec_link, row.pc + 32'd8);
    report_test(name);
  endtask

  task automatic make_random_row(input bit is_branch, output vec_row_t row);
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = $random(seed);
    r1 = $random(seed);
    row         = '0;
    row.pc      = {r1[31:2], 2'b00};
    row.len     = 2'd2;
    row.rfd     = r0[25:21];
    if (!is_branch) begin
      // addi with random registers and immediate
      row.insn    = {6'h27, r0[25:0]};
      row.ctl     = 6'b100000;
      row.zext    = 1'b1;
      row.imm     = {{16{r0[15]}}, r0[15:0]};
      row.imm_sel = 1'b1;
      row.wb_1clk = 2'b11;
    end else begin
      row.insn    = {6'h04, r0[25:0]};
      row.flag    = r0[31];
      row.jmp_br  = {1'b1, r0[31]};
      row.target  = row.pc + {{4{r0[25]}}, r0[25:0], 2'b00};
      row.alu     = 4'hf;
      row.ctl     = 6'b000001;
      row.wb_1clk = 2'b01;
    end
  endtask

  initial begin
    seed         = 32'h712aef2d;
    err_count    = 0;
    test_errs    = 0;
    test_count   = 0;
    failed_tests = 0;
    rst          = 1'b1;
    padv         = 1'b0;
    flush        = 1'b0;
    insn         = '0;
    insn_valid   = 1'b0;
    pc           = '0;
    flag         = 1'b0;

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    idle_control_check();
    report_test("reset state");

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_vector(VECTORS[i], $sformatf("row %0d insn %h", i, VECTORS[i].insn));
    end

    for (int i = 0; i < RND_ROWS; i++) begin
      make_random_row(i[0], rnd_row);
      run_vector(rnd_row, $sformatf("random %0d insn %h", i, rnd_row.insn));
    end

    // lwz stays in the latch while the inputs move on
    run_vector(VECTORS[9], "hold setup lwz");
    for (int c = 0; c < 4; c++) begin
      @(posedge clk);
      insn <= VECTORS[5].insn;
      pc   <= pc + 32'h4;
      @(negedge clk);
      expect_eq("exec_pc_o", exec_pc, VECTORS[9].pc);
      expect_eq("exec_op_o.lsu_load", 32'(exec_op.lsu_load), 32'd1);
      expect_eq("exec_imm_o", exec_imm, VECTORS[9].imm);
      expect_eq("exec_insn_1clk_o", 32'(exec_insn_1clk), 32'd0);
    end
    report_test("hold with advance low");

    @(posedge clk);
    padv  <= 1'b1;
    flush <= 1'b1;
    @(posedge clk);
    padv  <= 1'b0;
    flush <= 1'b0;
    @(negedge clk);
    idle_control_check();
    // data side keeps the lwz values
    expect_eq("exec_pc_o", exec_pc, VECTORS[9].pc);
    report_test("flush over advance");

    $display("tests %0d, failed tests %0d, errors %0d", test_count, failed_tests, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/or1k_dcod_top.sv */
// decode stage top, classifier and operand builder feeding the execute latch
`timescale 1ns/10ps
`default_nettype none

module or1k_dcod_top #(
  parameter int OPERAND_WIDTH  = 32,
  parameter bit ENABLE_SYSCALL = 1'b1,
  parameter bit ENABLE_TRAP    = 1'b1
) (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 padv_decode_i,
  input  wire                                 pipeline_flush_i,
  input  wire [or1k_dcod_pkg::INSN_W-1:0]     insn_i,
  input  wire                                 insn_valid_i,
  input  wire [OPERAND_WIDTH-1:0]             pc_i,
  input  wire                                 flag_i,
  // same-cycle outputs
  output wire [or1k_dcod_pkg::RF_ADDR_W-1:0]  rfa_adr_o,
  output wire [or1k_dcod_pkg::RF_ADDR_W-1:0]  rfb_adr_o,
  output wire                                 branch_o,
  output wire [OPERAND_WIDTH-1:0]             branch_target_o,
  // execute side
  output wire or1k_dcod_pkg::dcod_op_t        exec_op_o,
  output wire or1k_dcod_pkg::dcod_except_t    exec_except_o,
  output wire [OPERAND_WIDTH-1:0]             exec_imm_o,
  output wire                                 exec_imm_sel_o,
  output wire [or1k_dcod_pkg::RF_ADDR_W-1:0]  exec_rfd_adr_o,
  output wire                                 exec_rf_wb_o,
  output wire [OPERAND_WIDTH-1:0]             exec_link_o,
  output wire [OPERAND_WIDTH-1:0]             exec_pc_o,
  output wire                                 exec_insn_1clk_o,
  output wire                                 exec_excepts_en_o
);

  wire or1k_dcod_pkg::opcode_e        opcode;
  wire or1k_dcod_pkg::dcod_op_t       dcod_op;
  wire or1k_dcod_pkg::dcod_except_t   dcod_except;
  wire                                dcod_rf_wb;
  wire                                dcod_one_clock;
  wire [OPERAND_WIDTH-1:0]            dcod_imm;
  wire                                dcod_imm_sel;
  wire [or1k_dcod_pkg::RF_ADDR_W-1:0] dcod_rfd_adr;
  wire [OPERAND_WIDTH-1:0]            dcod_link;

  or1k_dcod_classify #(
    .ENABLE_SYSCALL (ENABLE_SYSCALL),
    .ENABLE_TRAP    (ENABLE_TRAP)
  ) classify_i (
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .opcode_o     (opcode),
    .op_o         (dcod_op),
    .except_o     (dcod_except),
    .rf_wb_o      (dcod_rf_wb),
    .one_clock_o  (dcod_one_clock)
  );

  or1k_dcod_operands #(
    .OPERAND_WIDTH (OPERAND_WIDTH)
  ) operands_i (
    .insn_i          (insn_i),
    .opcode_i        (opcode),
    .pc_i            (pc_i),
    .flag_i          (flag_i),
    .rfa_adr_o       (rfa_adr_o),
    .rfb_adr_o       (rfb_adr_o),
    .rfd_adr_o       (dcod_rfd_adr),
    .imm_o           (dcod_imm),
    .imm_sel_o       (dcod_imm_sel),
    .link_o          (dcod_link),
    .branch_o        (branch_o),
    .branch_target_o (branch_target_o)
  );

  or1k_dcod_exec_latch #(
    .OPERAND_WIDTH (OPERAND_WIDTH)
  ) exec_latch_i (
    .clk               (clk),
    .rst               (rst),
    .padv_decode_i     (padv_decode_i),
    .pipeline_flush_i  (pipeline_flush_i),
    .op_i              (dcod_op),
    .except_i          (dcod_except),
    .rf_wb_i           (dcod_rf_wb),
    .one_clock_i       (dcod_one_clock),
    .insn_valid_i      (insn_valid_i),
    .imm_i             (dcod_imm),
    .imm_sel_i         (dcod_imm_sel),
    .rfd_adr_i         (dcod_rfd_adr),
    .link_i            (dcod_link),
    .pc_i              (pc_i),
    .exec_op_o         (exec_op_o),
    .exec_except_o     (exec_except_o),
    .exec_rf_wb_o      (exec_rf_wb_o),
    .exec_insn_1clk_o  (exec_insn_1clk_o),
    .exec_excepts_en_o (exec_excepts_en_o),
    .exec_imm_o        (exec_imm_o),
    .exec_imm_sel_o    (exec_imm_sel_o),
    .exec_rfd_adr_o    (exec_rfd_adr_o),
    .exec_link_o       (exec_link_o),
    .exec_pc_o         (exec_pc_o)
  );

endmodule

`default_nettype wire

/* rtl/or1k_dcod_exec_latch.sv */
// decode to execute register with advance, flush and reset priority
`timescale 1ns/10ps
`default_nettype none

module or1k_dcod_exec_latch #(
  parameter int OPERAND_WIDTH = 32
) (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 padv_decode_i,
  input  wire                                 pipeline_flush_i,
  input  wire or1k_dcod_pkg::dcod_op_t        op_i,
  input  wire or1k_dcod_pkg::dcod_except_t    except_i,
  input  wire                                 rf_wb_i,
  input  wire                                 one_clock_i,
  input  wire                                 insn_valid_i,
  input  wire [OPERAND_WIDTH-1:0]             imm_i,
  input  wire                                 imm_sel_i,
  input  wire [or1k_dcod_pkg::RF_ADDR_W-1:0]  rfd_adr_i,
  input  wire [OPERAND_WIDTH-1:0]             link_i,
  input  wire [OPERAND_WIDTH-1:0]             pc_i,
  output or1k_dcod_pkg::dcod_op_t             exec_op_o,
  output or1k_dcod_pkg::dcod_except_t         exec_except_o,
  output logic                                exec_rf_wb_o,
  output logic                                exec_insn_1clk_o,
  output logic                                exec_excepts_en_o,
  output logic [OPERAND_WIDTH-1:0]            exec_imm_o,
  output logic                                exec_imm_sel_o,
  output logic [or1k_dcod_pkg::RF_ADDR_W-1:0] exec_rfd_adr_o,
  output logic [OPERAND_WIDTH-1:0]            exec_link_o,
  output logic [OPERAND_WIDTH-1:0]            exec_pc_o
);

  logic accept;

  // flush wins over advance
  assign accept = padv_decode_i & ~pipeline_flush_i;

  // control group, a flushed slot looks like a one-clock bubble
  always_ff @(posedge clk) begin
    if (rst || pipeline_flush_i) begin
      exec_op_o         <= '0;
      exec_except_o     <= '0;
      exec_rf_wb_o      <= 1'b0;
      exec_insn_1clk_o  <= 1'b1;
      exec_excepts_en_o <= 1'b0;
    end else if (padv_decode_i) begin
      exec_op_o         <= op_i;
      exec_except_o     <= except_i;
      exec_rf_wb_o      <= rf_wb_i;
      // syscall and trap just pass through execute
      exec_insn_1clk_o  <= one_clock_i | except_i.syscall | except_i.trap;
      exec_excepts_en_o <= insn_valid_i;
    end
  end

  // data group
  always_ff @(posedge clk) begin
    if (accept) begin
      exec_imm_o     <= imm_i;
      exec_imm_sel_o <= imm_sel_i;
      exec_rfd_adr_o <= rfd_adr_i;
      exec_link_o    <= link_i;
      exec_pc_o      <= pc_i;
    end
  end

  flush_clears_wb_a: assert property (@(posedge clk)
    pipeline_flush_i |=> !exec_rf_wb_o);

  hold_on_stall_a: assert property (@(posedge clk) disable iff (rst)
    (!padv_decode_i && !pipeline_flush_i) |=>
      ($stable(exec_op_o) && $stable(exec_except_o) && $stable(exec_rf_wb_o) &&
       $stable(exec_insn_1clk_o) && $stable(exec_excepts_en_o) &&
       $stable(exec_imm_o) && $stable(exec_imm_sel_o) && $stable(exec_rfd_adr_o) &&
       $stable(exec_link_o) && $stable(exec_pc_o)));

endmodule

`default_nettype wire

/* rtl/or1k_dcod_operands.sv */
// operand builder, immediate, register addresses, link value and immediate branch decision
`timescale 1ns/10ps
`default_nettype none

module or1k_dcod_operands #(
  parameter int OPERAND_WIDTH = 32
) (
  input  wire [or1k_dcod_pkg::INSN_W-1:0]     insn_i,
  input  wire or1k_dcod_pkg::opcode_e         opcode_i,
  input  wire [OPERAND_WIDTH-1:0]             pc_i,
  input  wire                                 flag_i,
  output logic [or1k_dcod_pkg::RF_ADDR_W-1:0] rfa_adr_o,
  output logic [or1k_dcod_pkg::RF_ADDR_W-1:0] rfb_adr_o,
  output logic [or1k_dcod_pkg::RF_ADDR_W-1:0] rfd_adr_o,
  output logic [OPERAND_WIDTH-1:0]            imm_o,
  output logic                                imm_sel_o,
  output logic [OPERAND_WIDTH-1:0]            link_o,
  output logic                                branch_o,
  output logic [OPERAND_WIDTH-1:0]            branch_target_o
);

  logic                            is_load;
  logic                            is_store;
  logic                            sext_sel;
  logic                            zext_sel;
  logic                            high_sel;
  logic [or1k_dcod_pkg::IMM_W-1:0] imm16;
  logic [OPERAND_WIDTH-1:0]        imm_sext;
  logic [OPERAND_WIDTH-1:0]        imm_zext;
  logic [OPERAND_WIDTH-1:0]        jb_offset;

  assign is_load  = opcode_i inside {or1k_dcod_pkg::OPC_LWZ, or1k_dcod_pkg::OPC_LWS,
                                     or1k_dcod_pkg::OPC_LBZ, or1k_dcod_pkg::OPC_LBS,
                                     or1k_dcod_pkg::OPC_LHZ, or1k_dcod_pkg::OPC_LHS};
  assign is_store = opcode_i inside {or1k_dcod_pkg::OPC_SW, or1k_dcod_pkg::OPC_SB,
                                     or1k_dcod_pkg::OPC_SH};

  // store immediate is split around the rb field
  assign imm16 = is_store ?
                 {insn_i[or1k_dcod_pkg::RD_LSB +: or1k_dcod_pkg::RF_ADDR_W],
                  insn_i[or1k_dcod_pkg::STIMM_LO_W-1:0]} :
                 insn_i[or1k_dcod_pkg::IMM_W-1:0];

  assign sext_sel = is_load | is_store |
                    (opcode_i inside {or1k_dcod_pkg::OPC_ADDI, or1k_dcod_pkg::OPC_ADDIC,
                                      or1k_dcod_pkg::OPC_XORI});
  assign zext_sel = opcode_i inside {or1k_dcod_pkg::OPC_ANDI, or1k_dcod_pkg::OPC_ORI};
  assign high_sel = (opcode_i == or1k_dcod_pkg::OPC_MOVHI);

  assign imm_sext = OPERAND_WIDTH'(signed'(imm16));
  assign imm_zext = OPERAND_WIDTH'(imm16);

  always_comb begin
    if (sext_sel) begin
      imm_o = imm_sext;
    end else if (zext_sel) begin
      imm_o = imm_zext;
    end else if (high_sel) begin
      imm_o = imm_zext << or1k_dcod_pkg::IMM_W;
    end else begin
      imm_o = '0;
    end
    one_imm_rule_a: assert ($onehot0({sext_sel, zext_sel, high_sel}));
  end

  assign imm_sel_o = sext_sel | zext_sel | high_sel;

  assign rfa_adr_o = insn_i[or1k_dcod_pkg::RA_LSB +: or1k_dcod_pkg::RF_ADDR_W];
  assign rfb_adr_o = insn_i[or1k_dcod_pkg::RB_LSB +: or1k_dcod_pkg::RF_ADDR_W];
  assign rfd_adr_o = (opcode_i == or1k_dcod_pkg::OPC_JAL) ? or1k_dcod_pkg::LINK_REG :
                     insn_i[or1k_dcod_pkg::RD_LSB +: or1k_dcod_pkg::RF_ADDR_W];

  // return past the delay slot
  assign link_o = pc_i + OPERAND_WIDTH'(8);

  // word offset, sign extended
  assign jb_offset       = OPERAND_WIDTH'(signed'(insn_i[or1k_dcod_pkg::JOFF_W-1:0])) << 2;
  assign branch_target_o = pc_i + jb_offset;

  assign branch_o = (opcode_i == or1k_dcod_pkg::OPC_J) |
                    (opcode_i == or1k_dcod_pkg::OPC_JAL) |
                    ((opcode_i == or1k_dcod_pkg::OPC_BF) & flag_i) |
                    ((opcode_i == or1k_dcod_pkg::OPC_BNF) & ~flag_i);

endmodule

`default_nettype wire

/* rtl/or1k_dcod_classify.sv */
// instruction classifier, opcode fields to operation flags, exceptions and one-clock flag
`timescale 1ns/10ps
`default_nettype none

module or1k_dcod_classify #(
  parameter bit ENABLE_SYSCALL = 1'b1,
  parameter bit ENABLE_TRAP    = 1'b1
) (
  input  wire [or1k_dcod_pkg::INSN_W-1:0] insn_i,
  input  wire                             insn_valid_i,
  output or1k_dcod_pkg::opcode_e          opcode_o,
  output or1k_dcod_pkg::dcod_op_t         op_o,
  output or1k_dcod_pkg::dcod_except_t     except_o,
  output logic                            rf_wb_o,
  output logic                            one_clock_o
);

  or1k_dcod_pkg::alu_opc_e alu_minor;
  or1k_dcod_pkg::sys_opc_e sys_opc;
  logic                    illegal;
  logic                    syscall;
  logic                    trap;

  assign opcode_o  = or1k_dcod_pkg::opcode_e'(
                       insn_i[or1k_dcod_pkg::OPC_LSB +: or1k_dcod_pkg::OPCODE_W]);
  assign alu_minor = or1k_dcod_pkg::alu_opc_e'(insn_i[or1k_dcod_pkg::ALU_OPC_W-1:0]);
  assign sys_opc   = or1k_dcod_pkg::sys_opc_e'(
                       insn_i[or1k_dcod_pkg::SYS_LSB +: or1k_dcod_pkg::SYS_OPC_W]);

  always_comb begin
    op_o          = '0;
    op_o.alu_opc  = or1k_dcod_pkg::ALU_NONE;
    // opcode bit 0 marks the zero-extending loads
    op_o.lsu_zext = insn_i[or1k_dcod_pkg::OPC_LSB];
    illegal       = 1'b0;
    syscall       = 1'b0;
    trap          = 1'b0;
    rf_wb_o       = 1'b0;
    one_clock_o   = 1'b1;

    case (opcode_o)
      or1k_dcod_pkg::OPC_J,
      or1k_dcod_pkg::OPC_NOP: begin
        illegal = 1'b0;
      end
      or1k_dcod_pkg::OPC_JAL: begin
        op_o.op_jal = 1'b1;
        rf_wb_o     = 1'b1;
      end
      or1k_dcod_pkg::OPC_BF,
      or1k_dcod_pkg::OPC_BNF: begin
        op_o.op_brcond = 1'b1;
      end
      or1k_dcod_pkg::OPC_MOVHI: begin
        op_o.op_movhi = 1'b1;
        rf_wb_o       = 1'b1;
      end
      // loads and stores take more than one clock in execute
      or1k_dcod_pkg::OPC_LWZ, or1k_dcod_pkg::OPC_LWS,
      or1k_dcod_pkg::OPC_LBZ, or1k_dcod_pkg::OPC_LBS,
      or1k_dcod_pkg::OPC_LHZ, or1k_dcod_pkg::OPC_LHS: begin
        op_o.lsu_load = 1'b1;
        rf_wb_o       = 1'b1;
        one_clock_o   = 1'b0;
      end
      or1k_dcod_pkg::OPC_SW, or1k_dcod_pkg::OPC_SB, or1k_dcod_pkg::OPC_SH: begin
        op_o.lsu_store = 1'b1;
        one_clock_o    = 1'b0;
      end
      or1k_dcod_pkg::OPC_ADDI,
      or1k_dcod_pkg::OPC_ADDIC: begin
        op_o.alu_opc  = or1k_dcod_pkg::ALU_ADD;
        op_o.op_add   = 1'b1;
        op_o.do_carry = (opcode_o == or1k_dcod_pkg::OPC_ADDIC);
        rf_wb_o       = 1'b1;
      end
      or1k_dcod_pkg::OPC_ANDI: begin
        op_o.alu_opc = or1k_dcod_pkg::ALU_AND;
        rf_wb_o      = 1'b1;
      end
      or1k_dcod_pkg::OPC_ORI: begin
        op_o.alu_opc = or1k_dcod_pkg::ALU_OR;
        rf_wb_o      = 1'b1;
      end
      or1k_dcod_pkg::OPC_XORI: begin
        op_o.alu_opc = or1k_dcod_pkg::ALU_XOR;
        rf_wb_o      = 1'b1;
      end
      or1k_dcod_pkg::OPC_ALU: begin
        case (alu_minor)
          or1k_dcod_pkg::ALU_ADD,
          or1k_dcod_pkg::ALU_ADDC,
          or1k_dcod_pkg::ALU_SUB: begin
            op_o.alu_opc  = alu_minor;
            op_o.op_add   = 1'b1;
            op_o.do_carry = (alu_minor == or1k_dcod_pkg::ALU_ADDC);
            op_o.do_sub   = (alu_minor == or1k_dcod_pkg::ALU_SUB);
            rf_wb_o       = 1'b1;
          end
          or1k_dcod_pkg::ALU_AND,
          or1k_dcod_pkg::ALU_OR,
          or1k_dcod_pkg::ALU_XOR: begin
            op_o.alu_opc = alu_minor;
            rf_wb_o      = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      // msync and the sync ops fall through to illegal
      or1k_dcod_pkg::OPC_SYSTRAPSYNC: begin
        if (ENABLE_SYSCALL && (sys_opc == or1k_dcod_pkg::SYS_SYSCALL)) begin
          syscall = 1'b1;
        end else if (ENABLE_TRAP && (sys_opc == or1k_dcod_pkg::SYS_TRAP)) begin
          trap = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    case (opcode_o)
      or1k_dcod_pkg::OPC_LBZ, or1k_dcod_pkg::OPC_LBS, or1k_dcod_pkg::OPC_SB:
        op_o.lsu_len = or1k_dcod_pkg::LSU_BYTE;
      or1k_dcod_pkg::OPC_LHZ, or1k_dcod_pkg::OPC_LHS, or1k_dcod_pkg::OPC_SH:
        op_o.lsu_len = or1k_dcod_pkg::LSU_HALF;
      default:
        op_o.lsu_len = or1k_dcod_pkg::LSU_WORD;
    endcase

    illegal_not_load_a: assert (!(illegal && op_o.lsu_load));
  end

  // an empty slot raises no exception
  assign except_o.illegal = insn_valid_i & illegal;
  assign except_o.syscall = insn_valid_i & syscall;
  assign except_o.trap    = insn_valid_i & trap;

endmodule

`default_nettype wire

/* rtl/or1k_dcod_pkg.sv */
// or1k decode stage shared widths, field positions, opcode enums and decoded-op structs
`default_nettype none

package or1k_dcod_pkg;

  // widths
  localparam int INSN_W     = 32;
  localparam int OPCODE_W   = 6;
  localparam int RF_ADDR_W  = 5;
  localparam int IMM_W      = 16;
  localparam int ALU_OPC_W  = 4;
  localparam int SYS_OPC_W  = 5;
  localparam int JOFF_W     = 26;
  localparam int STIMM_LO_W = 11;

  // field positions, lsb of each field
  localparam int OPC_LSB = 26;
  localparam int RD_LSB  = 21;
  localparam int RA_LSB  = 16;
  localparam int RB_LSB  = 11;
  localparam int SYS_LSB = 21;

  // jal writes the return address here
  localparam logic [RF_ADDR_W-1:0] LINK_REG = RF_ADDR_W'(9);

  // kept major opcodes
  typedef enum logic [OPCODE_W-1:0] {
    OPC_J           = 6'h00,
    OPC_JAL         = 6'h01,
    OPC_BNF         = 6'h03,
    OPC_BF          = 6'h04,
    OPC_NOP         = 6'h05,
    OPC_MOVHI       = 6'h06,
    OPC_SYSTRAPSYNC = 6'h08,
    OPC_LWZ         = 6'h21,
    OPC_LWS         = 6'h22,
    OPC_LBZ         = 6'h23,
    OPC_LBS         = 6'h24,
    OPC_LHZ         = 6'h25,
    OPC_LHS         = 6'h26,
    OPC_ADDI        = 6'h27,
    OPC_ADDIC       = 6'h28,
    OPC_ANDI        = 6'h29,
    OPC_ORI         = 6'h2a,
    OPC_XORI        = 6'h2b,
    OPC_SW          = 6'h35,
    OPC_SB          = 6'h36,
    OPC_SH          = 6'h37,
    OPC_ALU         = 6'h38
  } opcode_e;

  // alu minor field, also the execute alu opcode
  typedef enum logic [ALU_OPC_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_ADDC = 4'h1,
    ALU_SUB  = 4'h2,
    ALU_AND  = 4'h3,
    ALU_OR   = 4'h4,
    ALU_XOR  = 4'h5,
    ALU_NONE = 4'hf
  } alu_opc_e;

  // sub-opcode of l.sys / l.trap group
  typedef enum logic [SYS_OPC_W-1:0] {
    SYS_SYSCALL = 5'h00,
    SYS_TRAP    = 5'h08
  } sys_opc_e;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_len_e;

  // control word handed to execute
  typedef struct packed {
    alu_opc_e alu_opc;
    logic     op_add;
    logic     do_sub;
    logic     do_carry;
    logic     op_movhi;
    logic     lsu_load;
    logic     lsu_store;
    lsu_len_e lsu_len;
    logic     lsu_zext;
    logic     op_jal;
    logic     op_brcond;
  } dcod_op_t;

  typedef struct packed {
    logic illegal;
    logic syscall;
    logic trap;
  } dcod_except_t;

endpackage

`default_nettype wire
